// File: rtl/scope_pkg.sv
// Shared sizes, register map and data types for the scope capture subsystem
// Every RTL file refers to these through scoped names, so one edit here
// resizes the channel count, the sample width or the capture depth everywhere
`default_nettype none

package scope_pkg;

    // Channel and sample geometry
    localparam int n_channels    = 4;
    localparam int sample_width  = 16;
    localparam int dest_width    = 8;
    localparam int capture_depth = 16;

    // Address width of the capture memory and its read port
    localparam int capture_addr_width = $clog2(capture_depth);

    // Three address bits of the register bus give 8 word slots
    localparam int addr_width = 3;
    localparam int reg_width  = 32;

    // Register map with one selector word per channel
    localparam int reg_ctrl     = 0;
    localparam int reg_sel_base = 1;
    localparam int reg_divisor  = reg_sel_base + n_channels;
    localparam int num_regs     = reg_divisor + 1;

    // Control word layout with arm in bit 0 and external capture in bit 24
    localparam int ctrl_arm_bit         = 0;
    localparam int ctrl_ext_capture_bit = 24;

    // Only the low half of the divisor word drives the timebase counter
    localparam int divisor_width = 16;

    // One beat of the tagged input stream
    typedef struct packed {
        logic                    valid;
        logic [dest_width-1:0]   dest;
        logic [sample_width-1:0] data;
    } stream_beat_t;

    // One captured frame where lane i belongs to channel i
    typedef struct packed {
        logic [n_channels-1:0][sample_width-1:0] samples;
    } frame_t;

    // Decoded configuration that fans out from the register block
    typedef struct packed {
        logic                                  arm;
        logic                                  ext_capture;
        logic [divisor_width-1:0]              divisor;
        logic [n_channels-1:0][dest_width-1:0] sel;
    } scope_cfg_t;

endpackage

`default_nettype wire

// File: rtl/scope_regs.sv
// Register block of the scope: control word, one tag selector per channel
// and the timebase divisor, written through a plain strobe bus
// Reads return the stored words unchanged and unmapped slots read as zero
`timescale 1ns/100ps
`default_nettype none

module scope_regs (
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire                              reg_wr,
    input  wire [scope_pkg::addr_width-1:0]  reg_addr,
    input  wire [scope_pkg::reg_width-1:0]   reg_wdata,
    output logic [scope_pkg::reg_width-1:0]  reg_rdata,
    output scope_pkg::scope_cfg_t            cfg
);

    // Raw register words, slot 0 is control, then the selectors, then the divisor
    logic [scope_pkg::num_regs-1:0][scope_pkg::reg_width-1:0] regs;

    // High when the bus address falls on one of the mapped words
    logic addr_hit;

    assign addr_hit = (int'(reg_addr) < scope_pkg::num_regs);

    // A write lands on the same edge that samples the strobe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (reg_wr && addr_hit) begin
            regs[reg_addr] <= reg_wdata;
        end
    end

    // Readback is combinational so the bus master sees data in the address cycle
    always_comb begin
        if (addr_hit) begin
            reg_rdata = regs[reg_addr];
        end else begin
            reg_rdata = '0;
        end
    end

    // Field decode of the stored words into the configuration struct
    always_comb begin
        cfg.arm         = regs[scope_pkg::reg_ctrl][scope_pkg::ctrl_arm_bit];
        cfg.ext_capture = regs[scope_pkg::reg_ctrl][scope_pkg::ctrl_ext_capture_bit];
        cfg.divisor     = regs[scope_pkg::reg_divisor][scope_pkg::divisor_width-1:0];
        // Each selector keeps only the tag width of its word
        for (int ch = 0; ch < scope_pkg::n_channels; ch++) begin
            cfg.sel[ch] = regs[scope_pkg::reg_sel_base + ch][scope_pkg::dest_width-1:0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/scope_timebase.sv
// Sample strobe generator for the scope
// The strobe comes from an internal divider (one pulse every divisor+1 cycles)
// or from rising edges of a synchronized external sampling clock
`timescale 1ns/100ps
`default_nettype none

module scope_timebase (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   sampling_clock,
    input  scope_pkg::scope_cfg_t cfg,
    output logic                  sample_strb
);

    logic [scope_pkg::divisor_width-1:0] div_cnt;
    logic [scope_pkg::divisor_width-1:0] div_q;
    logic                                ext_q;
    logic                                cfg_changed;
    logic                                int_tick;
    // Stages 0 and 1 form the synchronizer, stage 2 is the edge history
    logic [2:0]                          ext_sync;
    logic                                ext_rise;

    // Any change of mode or divisor restarts the divider from zero
    assign cfg_changed = (cfg.divisor != div_q) || (cfg.ext_capture != ext_q);

    // The divider fires when the count reaches the divisor, so D=0 fires every cycle
    assign int_tick = !cfg_changed && (div_cnt == cfg.divisor);

    assign ext_rise = ext_sync[1] & ~ext_sync[2];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            div_q       <= '0;
            ext_q       <= 1'b0;
            ext_sync    <= '0;
            sample_strb <= 1'b0;
        end else begin
            div_q    <= cfg.divisor;
            ext_q    <= cfg.ext_capture;
            ext_sync <= {ext_sync[1:0], sampling_clock};
            if (cfg_changed || int_tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // Registered select keeps the strobe a clean one-cycle pulse
            sample_strb <= cfg.ext_capture ? ext_rise : int_tick;
        end
    end

endmodule

`default_nettype wire

// File: rtl/channel_latch.sv
// Per-channel stage of the scope
// Keeps the newest stream beat whose tag equals the channel selector and
// repeats that held value into the frame lane at every sample strobe
`timescale 1ns/100ps
`default_nettype none

module channel_latch (
    input  wire                                clock,
    input  wire                                rst_n,
    input  scope_pkg::stream_beat_t            s_beat,
    input  wire [scope_pkg::dest_width-1:0]    sel,
    input  wire                                sample_strb,
    output logic [scope_pkg::sample_width-1:0] sample,
    output logic                               sample_valid
);

    // Newest matching data, reads as zero until the first match after reset
    logic [scope_pkg::sample_width-1:0] held;
    logic                               beat_match;

    assign beat_match = s_beat.valid && (s_beat.dest == sel);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held <= '0;
        end else if (beat_match) begin
            held <= s_beat.data;
        end
    end

    // A strobe takes the value held before any beat arriving in the same cycle
    always_ff @(posedge clock) begin
        if (sample_strb) begin
            sample <= held;
        end
    end

    // Valid lines up with the lane update, one cycle after the strobe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sample_strb;
        end
    end

endmodule

`default_nettype wire

// File: rtl/capture_buffer.sv
// Frame memory of the scope with arm, trigger and done handling
// A rising edge of arm starts a capture of capture_depth frames, after which
// done holds until the next rearm and the frames are read back by address
`timescale 1ns/100ps
`default_nettype none

module capture_buffer (
    input  wire                                      clock,
    input  wire                                      rst_n,
    input  wire                                      arm,
    input  scope_pkg::frame_t                        frame,
    input  wire                                      frame_valid,
    input  wire [scope_pkg::capture_addr_width-1:0]  rd_addr,
    output scope_pkg::frame_t                        rd_data,
    output logic                                     trigger,
    output logic                                     done
);

    // One entry per captured frame
    scope_pkg::frame_t mem [scope_pkg::capture_depth];

    // Write pointer doubles as the frame counter of the running capture
    logic [scope_pkg::capture_addr_width-1:0] wr_ptr;
    logic                                     arm_q;
    logic                                     arm_rise;
    logic                                     wr_en;
    logic                                     last_frame;

    assign arm_rise = arm & ~arm_q;

    // A frame arriving in the rearm cycle is dropped since the counter is clearing
    assign wr_en = frame_valid && arm && !done && !arm_rise;

    assign last_frame = (int'(wr_ptr) == scope_pkg::capture_depth - 1);

    // The first write of a capture marks the trigger point
    assign trigger = wr_en && (wr_ptr == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            arm_q <= 1'b0;
        end else begin
            arm_q <= arm;
        end
    end

    // Counter and done flag of the capture in progress
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            done   <= 1'b0;
        end else if (arm_rise) begin
            wr_ptr <= '0;
            done   <= 1'b0;
        end else if (wr_en) begin
            // Pointer wraps to zero on the last frame, done then blocks further writes
            wr_ptr <= wr_ptr + 1'b1;
            if (last_frame) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= frame;
        end
    end

    // Synchronous readout, data follows the address by one cycle
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: rtl/scope_capture_top.sv
// Top level of the scope capture subsystem
// Registers feed the configuration to the timebase, one latch per channel
// builds each frame from the tagged stream and the buffer stores a capture
`timescale 1ns/100ps
`default_nettype none

module scope_capture_top (
    input  wire                                      clock,
    input  wire                                      rst_n,
    input  wire                                      sampling_clock,
    input  scope_pkg::stream_beat_t                  s_beat,
    input  wire                                      reg_wr,
    input  wire [scope_pkg::addr_width-1:0]          reg_addr,
    input  wire [scope_pkg::reg_width-1:0]           reg_wdata,
    input  wire [scope_pkg::capture_addr_width-1:0]  rd_addr,
    output wire [scope_pkg::reg_width-1:0]           reg_rdata,
    output scope_pkg::frame_t                        rd_data,
    output wire                                      trigger,
    output wire                                      done
);

    wire scope_pkg::scope_cfg_t          cfg;
    wire                                 sample_strb;
    wire scope_pkg::frame_t              frame;
    wire [scope_pkg::n_channels-1:0]     lane_valid;
    wire                                 frame_valid;

    scope_regs u_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .cfg       (cfg)
    );

    scope_timebase u_timebase (
        .clock          (clock),
        .rst_n          (rst_n),
        .sampling_clock (sampling_clock),
        .cfg            (cfg),
        .sample_strb    (sample_strb)
    );

    // Every lane sees the same strobe, so the lane valids all pulse together
    for (genvar i = 0; i < scope_pkg::n_channels; i++) begin : g_lane
        channel_latch u_latch (
            .clock        (clock),
            .rst_n        (rst_n),
            .s_beat       (s_beat),
            .sel          (cfg.sel[i]),
            .sample_strb  (sample_strb),
            .sample       (frame.samples[i]),
            .sample_valid (lane_valid[i])
        );
    end

    // Equal to the first lane valid since the lanes never differ
    assign frame_valid = &lane_valid;

    capture_buffer u_buffer (
        .clock       (clock),
        .rst_n       (rst_n),
        .arm         (cfg.arm),
        .frame       (frame),
        .frame_valid (frame_valid),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .trigger     (trigger),
        .done        (done)
    );

endmodule

`default_nettype wire

// File: verif/scope_capture_sva.sv
// Concurrent checks on the strobe, trigger and done behavior of the scope
// Bound into every scope_capture_top instance by the bind at the end
`timescale 1ns/100ps
`default_nettype none

module scope_capture_sva (
    input wire                        clock,
    input wire                        rst_n,
    input wire scope_pkg::scope_cfg_t cfg,
    input wire                        sample_strb,
    input wire                        frame_valid,
    input wire                        trigger,
    input wire                        done
);

    // Once done is high no trigger follows until arm rises again
    trigger_after_done: assert property (@(posedge clock) disable iff (!rst_n)
        done && !$rose(cfg.arm) |=> !trigger)
        else $error("trigger pulsed after done without a new rising edge of arm");

    // With a nonzero divisor the internal strobe is at most one cycle in D+1
    strobe_spacing: assert property (@(posedge clock) disable iff (!rst_n)
        sample_strb && !cfg.ext_capture && (cfg.divisor != '0) |=> !sample_strb)
        else $error("sample strobe high on two cycles in a row");

    // Done only clears through a drop and rise of arm
    done_holds: assert property (@(posedge clock) disable iff (!rst_n)
        done && cfg.arm && $past(cfg.arm) |=> done)
        else $error("done fell while arm stayed high");

    // Lanes update one cycle after the strobe that sampled them
    valid_after_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        frame_valid |-> $past(sample_strb))
        else $error("frame_valid without a sample strobe one cycle earlier");

endmodule

bind scope_capture_top scope_capture_sva u_sva (
    .clock       (clock),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .sample_strb (sample_strb),
    .frame_valid (frame_valid),
    .trigger     (trigger),
    .done        (done)
);

`default_nettype wire

// File: verif/scope_capture_tb.sv
// Testbench for the scope capture subsystem
// Checks register readback, then runs table-driven captures in internal and
// external strobe modes and compares every stored frame with a channel model
`timescale 1ns/100ps
`default_nettype none

module scope_capture_tb;

    // One capture scenario whose window for frame k sends tags k, k+1 and on (mod 4)
    typedef struct packed {
        logic [scope_pkg::n_channels-1:0][scope_pkg::dest_width-1:0] sel;
        logic [3:0][scope_pkg::dest_width-1:0]                       tags;
        logic [15:0]                                                 divisor;
        logic                                                        ext;
        logic [2:0]                                                  n_beats;
    } capture_row_t;

    localparam int num_rows   = 4;
    localparam int wait_limit = 400;

    logic                                     clock;
    logic                                     rst_n;
    logic                                     sampling_clock;
    scope_pkg::stream_beat_t                  s_beat;
    logic                                     reg_wr;
    logic [scope_pkg::addr_width-1:0]         reg_addr;
    logic [scope_pkg::reg_width-1:0]          reg_wdata;
    logic [scope_pkg::capture_addr_width-1:0] rd_addr;
    wire  [scope_pkg::reg_width-1:0]          reg_rdata;
    wire  scope_pkg::frame_t                  rd_data;
    wire                                      trigger;
    wire                                      done;

    capture_row_t      rows [num_rows];
    // Model of the held value of every lane under the matching rule
    scope_pkg::frame_t model;
    scope_pkg::frame_t expected [scope_pkg::capture_depth];
    logic [scope_pkg::n_channels-1:0][scope_pkg::dest_width-1:0] cur_sel;
    integer seed;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     trig_count;

    scope_capture_top dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .sampling_clock (sampling_clock),
        .s_beat         (s_beat),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .rd_addr        (rd_addr),
        .reg_rdata      (reg_rdata),
        .rd_data        (rd_data),
        .trigger        (trigger),
        .done           (done)
    );

    always #20 clock = ~clock;

    // Trigger is counted mid-cycle away from the edge that moves it
    always @(negedge clock) begin
        if (rst_n && trigger) begin
            trig_count++;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("time %0t: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    // All bus and stream tasks start and end on a falling edge
    task automatic write_reg(input int addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr[scope_pkg::addr_width-1:0];
        reg_wdata = data;
        @(negedge clock);
        reg_wr = 1'b0;
    endtask

    task automatic check_reg(input int addr, input logic [31:0] exp_val);
        reg_addr = addr[scope_pkg::addr_width-1:0];
        @(posedge clock);
        if (reg_rdata !== exp_val) report_mismatch($sformatf("reg_rdata[%0d]", addr), exp_val,
                                                   reg_rdata);
        @(negedge clock);
    endtask

    task automatic send_beat(input logic valid, input logic [7:0] tag);
        logic [15:0] data;
        data = $random(seed);
        s_beat.valid = valid;
        s_beat.dest  = tag;
        s_beat.data  = data;
        for (int ch = 0; ch < scope_pkg::n_channels; ch++) begin
            if (valid && tag == cur_sel[ch]) begin
                model.samples[ch] = data;
            end
        end
        @(negedge clock);
        s_beat.valid = 1'b0;
    endtask

    // The last of the n_beats+1 beats has valid low and must change nothing
    task automatic send_window(input capture_row_t row, input int k);
        for (int j = 0; j < row.n_beats; j++) begin
            send_beat(1'b1, row.tags[(k + j) % 4]);
        end
        send_beat(1'b0, row.tags[k % 4]);
    endtask

    task automatic wait_for(input bit on_done, output bit seen);
        seen = 1'b0;
        for (int i = 0; i < wait_limit && !seen; i++) begin
            seen = on_done ? done : trigger;
            if (!seen) begin
                @(negedge clock);
            end
        end
        if (!seen) report_failure(on_done ? "timeout waiting for done" :
                                            "timeout waiting for trigger");
    endtask

    task automatic test_readback();
        logic [31:0] written [8];
        // Every slot reads zero out of reset
        for (int a = 0; a < 8; a++) begin
            check_reg(a, 32'h0);
        end
        for (int a = 0; a < 8; a++) begin
            written[a] = $random(seed);
            // Arm stays low so no capture starts here
            if (a == scope_pkg::reg_ctrl) written[a][scope_pkg::ctrl_arm_bit] = 1'b0;
            write_reg(a, written[a]);
        end
        for (int a = 0; a < 8; a++) begin
            check_reg(a, (a < scope_pkg::num_regs) ? written[a] : 32'h0);
        end
    endtask

    task automatic run_capture(input capture_row_t row);
        logic [31:0] ctrl;
        bit          seen;
        cur_sel = row.sel;
        ctrl    = 32'(row.ext) << scope_pkg::ctrl_ext_capture_bit;
        // Disarm first so the arm write below is a fresh rising edge
        write_reg(scope_pkg::reg_ctrl, ctrl);
        for (int ch = 0; ch < scope_pkg::n_channels; ch++) begin
            write_reg(scope_pkg::reg_sel_base + ch, 32'(row.sel[ch]));
        end
        write_reg(scope_pkg::reg_divisor, 32'(row.divisor));
        if (!row.ext) send_window(row, 0);
        trig_count = 0;
        write_reg(scope_pkg::reg_ctrl, ctrl | (32'd1 << scope_pkg::ctrl_arm_bit));
        @(negedge clock);
        if (done !== 1'b0) report_failure("done did not clear on the rising edge of arm");
        if (!row.ext) begin
            // Frame 0 holds the preload and later frames follow every D+1 cycles
            expected[0] = model;
            wait_for(1'b0, seen);
            for (int k = 1; k < scope_pkg::capture_depth && seen; k++) begin
                send_window(row, k);
                repeat (int'(row.divisor) - int'(row.n_beats)) @(negedge clock);
                expected[k] = model;
            end
        end else begin
            for (int k = 0; k < scope_pkg::capture_depth; k++) begin
                send_window(row, k);
                expected[k] = model;
                if (k == scope_pkg::capture_depth - 1 && done !== 1'b0)
                    report_failure("done rose before the last external edge");
                sampling_clock = 1'b1;
                repeat (6) @(negedge clock);
                sampling_clock = 1'b0;
                repeat (6) @(negedge clock);
            end
        end
        wait_for(1'b1, seen);
        if (trig_count != 1) report_mismatch("trigger pulse count", 64'd1, 64'(trig_count));
        for (int a = 0; a < scope_pkg::capture_depth; a++) begin
            rd_addr = a[scope_pkg::capture_addr_width-1:0];
            @(negedge clock);
            if (rd_data !== expected[a]) report_mismatch($sformatf("rd_data[%0d]", a),
                                                         expected[a], rd_data);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (test_errors == 0) ? "ok" : "failed");
        test_errors = 0;
    endtask

    initial begin
        seed           = 33;
        clock          = 1'b0;
        rst_n          = 1'b0;
        sampling_clock = 1'b0;
        s_beat         = '0;
        reg_wr         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        rd_addr        = '0;
        model          = '0;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        trig_count     = 0;
        // Lane 3 of row 0 selects a tag that is never sent and must read zero
        rows[0] = '{32'h7F302010, 32'hEE302010, 16'd5, 1'b0, 3'd2};
        rows[1] = '{32'h10212030, 32'h21201030, 16'd3, 1'b0, 3'd1};
        rows[2] = '{32'h41424344, 32'h44434241, 16'd2, 1'b1, 3'd3};
        rows[3] = '{32'h7F302010, 32'h10102030, 16'd9, 1'b0, 3'd3};
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        test_readback();
        finish_test("register readback");
        for (int r = 0; r < num_rows; r++) begin
            run_capture(rows[r]);
            finish_test($sformatf("capture row %0d (%s)", r,
                                  rows[r].ext ? "external" : "internal"));
        end
        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: scope_capture.f
rtl/scope_pkg.sv
rtl/scope_regs.sv
rtl/scope_timebase.sv
rtl/channel_latch.sv
rtl/capture_buffer.sv
rtl/scope_capture_top.sv
verif/scope_capture_sva.sv
verif/scope_capture_tb.sv
